// ==== verilog/rv_decode_pkg.sv ====
package rv_decode_pkg;

  localparam int XLEN     = 64;             // Register and data width
  localparam int ILEN     = 32;             // Instruction width
  localparam int REGNO_W  = 5;
  localparam int NUM_REGS = 32;

  // Major opcodes, instr[6:0]
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_LOAD      = 7'b0000011;
  localparam logic [6:0] OPC_STORE     = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;

  localparam int OPCLASS_W = 4;

  localparam logic [OPCLASS_W-1:0] CLS_NONE    = 4'd0;  // Bubble or illegal
  localparam logic [OPCLASS_W-1:0] CLS_ALU_REG = 4'd1;
  localparam logic [OPCLASS_W-1:0] CLS_ALU_IMM = 4'd2;
  localparam logic [OPCLASS_W-1:0] CLS_LOAD    = 4'd3;
  localparam logic [OPCLASS_W-1:0] CLS_STORE   = 4'd4;
  localparam logic [OPCLASS_W-1:0] CLS_BRANCH  = 4'd5;
  localparam logic [OPCLASS_W-1:0] CLS_LUI     = 4'd6;
  localparam logic [OPCLASS_W-1:0] CLS_AUIPC   = 4'd7;
  localparam logic [OPCLASS_W-1:0] CLS_JAL     = 4'd8;
  localparam logic [OPCLASS_W-1:0] CLS_JALR    = 4'd9;

  // One instruction word, six format views
  typedef union packed {
    struct packed {
      logic [6:0]         funct7;
      logic [REGNO_W-1:0] rs2;
      logic [REGNO_W-1:0] rs1;
      logic [2:0]         funct3;
      logic [REGNO_W-1:0] rd;
      logic [6:0]         opcode;
    } r;
    struct packed {
      logic [11:0]        imm_11_0;
      logic [REGNO_W-1:0] rs1;
      logic [2:0]         funct3;
      logic [REGNO_W-1:0] rd;
      logic [6:0]         opcode;
    } i;
    struct packed {
      logic [6:0]         imm_11_5;
      logic [REGNO_W-1:0] rs2;
      logic [REGNO_W-1:0] rs1;
      logic [2:0]         funct3;
      logic [4:0]         imm_4_0;
      logic [6:0]         opcode;
    } s;
    struct packed {
      logic               imm_12;
      logic [5:0]         imm_10_5;
      logic [REGNO_W-1:0] rs2;
      logic [REGNO_W-1:0] rs1;
      logic [2:0]         funct3;
      logic [3:0]         imm_4_1;
      logic               imm_11;
      logic [6:0]         opcode;
    } b;
    struct packed {
      logic [19:0]        imm_31_12;
      logic [REGNO_W-1:0] rd;
      logic [6:0]         opcode;
    } u;
    struct packed {
      logic               imm_20;
      logic [9:0]         imm_10_1;
      logic               imm_11;
      logic [7:0]         imm_19_12;
      logic [REGNO_W-1:0] rd;
      logic [6:0]         opcode;
    } j;
  } instr_word_t;

endpackage

// ==== verilog/instr_field_decoder.sv ====
module instr_field_decoder import rv_decode_pkg::*; (
  input  logic [ILEN-1:0]      instr,
  output logic [REGNO_W-1:0]   rs1_regno,
  output logic [REGNO_W-1:0]   rs2_regno,
  output logic [REGNO_W-1:0]   rd_regno,
  output logic [XLEN-1:0]      imm,
  output logic [OPCLASS_W-1:0] op_class
);

  instr_word_t iw;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  logic uses_rs1;
  logic uses_rs2;
  logic uses_rd;

  assign iw = instr;

  // Immediates for every format, sign taken from instr[31]
  assign imm_i = {{(XLEN-12){iw.i.imm_11_0[11]}}, iw.i.imm_11_0};

  assign imm_s = {{(XLEN-12){iw.s.imm_11_5[6]}}, iw.s.imm_11_5, iw.s.imm_4_0};

  assign imm_b = {{(XLEN-13){iw.b.imm_12}},
                  iw.b.imm_12,
                  iw.b.imm_11,
                  iw.b.imm_10_5,
                  iw.b.imm_4_1,
                  1'b0};

  assign imm_u = {{(XLEN-32){iw.u.imm_31_12[19]}}, iw.u.imm_31_12, 12'b0};

  assign imm_j = {{(XLEN-21){iw.j.imm_20}},
                  iw.j.imm_20,
                  iw.j.imm_19_12,
                  iw.j.imm_11,
                  iw.j.imm_10_1,
                  1'b0};

  // Format and class from the opcode
  always_comb begin
    op_class = CLS_NONE;
    imm      = '0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    uses_rd  = 1'b0;
    case (iw.r.opcode)
      OPC_OP, OPC_OP_32: begin              // R format
        op_class = CLS_ALU_REG;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        uses_rd  = 1'b1;
      end
      OPC_OP_IMM, OPC_OP_IMM_32: begin
        op_class = CLS_ALU_IMM;
        imm      = imm_i;
        uses_rs1 = 1'b1;
        uses_rd  = 1'b1;
      end
      OPC_LOAD: begin
        op_class = CLS_LOAD;
        imm      = imm_i;
        uses_rs1 = 1'b1;
        uses_rd  = 1'b1;
      end
      OPC_JALR: begin
        op_class = CLS_JALR;
        imm      = imm_i;
        uses_rs1 = 1'b1;
        uses_rd  = 1'b1;
      end
      OPC_STORE: begin
        op_class = CLS_STORE;
        imm      = imm_s;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      OPC_BRANCH: begin
        op_class = CLS_BRANCH;
        imm      = imm_b;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      OPC_LUI: begin
        op_class = CLS_LUI;
        imm      = imm_u;
        uses_rd  = 1'b1;
      end
      OPC_AUIPC: begin
        op_class = CLS_AUIPC;
        imm      = imm_u;
        uses_rd  = 1'b1;
      end
      OPC_JAL: begin
        op_class = CLS_JAL;
        imm      = imm_j;
        uses_rd  = 1'b1;
      end
      default: begin
        op_class = CLS_NONE;                // Illegal, all fields stay zero
      end
    endcase
  end

  // Register fields sit at the same bits in every format that has them
  assign rs1_regno = uses_rs1 ? iw.r.rs1 : '0;
  assign rs2_regno = uses_rs2 ? iw.r.rs2 : '0;
  assign rd_regno  = uses_rd  ? iw.r.rd  : '0;

endmodule

// ==== verilog/register_file.sv ====
module register_file import rv_decode_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [REGNO_W-1:0] rs1_regno,
  input  logic [REGNO_W-1:0] rs2_regno,
  input  logic               wr_enable,
  input  logic [REGNO_W-1:0] wr_regno,
  input  logic [XLEN-1:0]    wr_value,
  output logic [XLEN-1:0]    rs1_value,
  output logic [XLEN-1:0]    rs2_value
);

  logic [XLEN-1:0] regs [NUM_REGS];

  // Read port with write-first bypass, x0 reads zero
  function automatic logic [XLEN-1:0] read_port(
    input logic [REGNO_W-1:0] regno,
    input logic               wen,
    input logic [REGNO_W-1:0] wregno,
    input logic [XLEN-1:0]    wvalue,
    input logic [XLEN-1:0]    stored
  );
    logic [XLEN-1:0] result;
    if (regno == '0) begin
      result = '0;
    end else if (wen && (wregno == regno)) begin
      result = wvalue;                      // Bypass the write in flight
    end else begin
      result = stored;
    end
    return result;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < NUM_REGS; k++) begin
        regs[k] <= '0;
      end
    end else if (wr_enable && (wr_regno != '0)) begin
      regs[wr_regno] <= wr_value;           // x0 writes dropped
    end
  end

  assign rs1_value = read_port(rs1_regno, wr_enable, wr_regno, wr_value, regs[rs1_regno]);
  assign rs2_value = read_port(rs2_regno, wr_enable, wr_regno, wr_value, regs[rs2_regno]);

endmodule

// ==== verilog/decode_stage.sv ====
module decode_stage import rv_decode_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 decode_enable,
  input  logic                 flush,
  input  logic [XLEN-1:0]      pc_next,
  input  logic [ILEN-1:0]      instr,
  input  logic                 wb_enable,
  input  logic [REGNO_W-1:0]   wb_regno,
  input  logic [XLEN-1:0]      wb_value,
  output logic                 ex_valid,
  output logic [XLEN-1:0]      ex_pc_next,
  output logic [REGNO_W-1:0]   ex_rs1_regno,
  output logic [REGNO_W-1:0]   ex_rs2_regno,
  output logic [REGNO_W-1:0]   ex_rd_regno,
  output logic [XLEN-1:0]      ex_rs1_value,
  output logic [XLEN-1:0]      ex_rs2_value,
  output logic [XLEN-1:0]      ex_imm,
  output logic [OPCLASS_W-1:0] ex_op_class
);

  logic [REGNO_W-1:0]   rs1_regno;
  logic [REGNO_W-1:0]   rs2_regno;
  logic [REGNO_W-1:0]   rd_regno;
  logic [XLEN-1:0]      imm;
  logic [OPCLASS_W-1:0] op_class;
  logic [XLEN-1:0]      rs1_value;
  logic [XLEN-1:0]      rs2_value;

  instr_field_decoder i_instr_field_decoder (
    .instr     (instr),
    .rs1_regno (rs1_regno),
    .rs2_regno (rs2_regno),
    .rd_regno  (rd_regno),
    .imm       (imm),
    .op_class  (op_class)
  );

  // Writeback goes straight to the write port
  register_file i_register_file (
    .clk       (clk),
    .rst_n     (rst_n),
    .rs1_regno (rs1_regno),
    .rs2_regno (rs2_regno),
    .wr_enable (wb_enable),
    .wr_regno  (wb_regno),
    .wr_value  (wb_value),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value)
  );

  // Decode to execute pipeline register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid     <= 1'b0;
      ex_pc_next   <= '0;
      ex_rs1_regno <= '0;
      ex_rs2_regno <= '0;
      ex_rd_regno  <= '0;
      ex_rs1_value <= '0;
      ex_rs2_value <= '0;
      ex_imm       <= '0;
      ex_op_class  <= CLS_NONE;
    end else if (decode_enable) begin
      if (flush) begin                      // Taken branch, insert bubble
        ex_valid     <= 1'b0;
        ex_pc_next   <= '0;
        ex_rs1_regno <= '0;
        ex_rs2_regno <= '0;
        ex_rd_regno  <= '0;
        ex_rs1_value <= '0;
        ex_rs2_value <= '0;
        ex_imm       <= '0;
        ex_op_class  <= CLS_NONE;
      end else begin
        ex_valid     <= 1'b1;
        ex_pc_next   <= pc_next;
        ex_rs1_regno <= rs1_regno;
        ex_rs2_regno <= rs2_regno;
        ex_rd_regno  <= rd_regno;
        ex_rs1_value <= rs1_value;
        ex_rs2_value <= rs2_value;
        ex_imm       <= imm;
        ex_op_class  <= op_class;
      end
    end
  end

endmodule

// ==== test/decode_stage_sva.sv ====
module decode_stage_sva import rv_decode_pkg::*; (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 decode_enable,
  input logic                 flush,
  input logic                 ex_valid,
  input logic [XLEN-1:0]      ex_pc_next,
  input logic [REGNO_W-1:0]   ex_rs1_regno,
  input logic [REGNO_W-1:0]   ex_rs2_regno,
  input logic [REGNO_W-1:0]   ex_rd_regno,
  input logic [XLEN-1:0]      ex_rs1_value,
  input logic [XLEN-1:0]      ex_rs2_value,
  input logic [XLEN-1:0]      ex_imm,
  input logic [OPCLASS_W-1:0] ex_op_class
);

  a_reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !ex_valid)
    else $error("ex_valid set in the cycle after reset");

  a_flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    decode_enable && flush |=> !ex_valid && (ex_imm == '0))
    else $error("Flush did not produce a bubble");

  // Back-pressure keeps the whole register
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    !decode_enable |=> $stable(ex_valid) && $stable(ex_pc_next) && $stable(ex_imm)
      && $stable(ex_rs1_regno) && $stable(ex_rs2_regno) && $stable(ex_rd_regno)
      && $stable(ex_rs1_value) && $stable(ex_rs2_value) && $stable(ex_op_class))
    else $error("Outputs changed while decode_enable was low");

  a_no_rd_store_branch: assert property (@(posedge clk) disable iff (!rst_n)
    (ex_op_class == CLS_STORE || ex_op_class == CLS_BRANCH) |-> ex_rd_regno == '0)
    else $error("Store or branch carries a destination register");

endmodule

bind decode_stage decode_stage_sva i_decode_stage_sva (.*);

// ==== test/tb_decode_stage.sv ====
module tb_decode_stage import rv_decode_pkg::*; ();

  logic                 clk;
  logic                 rst_n;
  logic                 decode_enable;
  logic                 flush;
  logic [XLEN-1:0]      pc_next;
  logic [ILEN-1:0]      instr;
  logic                 wb_enable;
  logic [REGNO_W-1:0]   wb_regno;
  logic [XLEN-1:0]      wb_value;
  logic                 ex_valid;
  logic [XLEN-1:0]      ex_pc_next;
  logic [REGNO_W-1:0]   ex_rs1_regno;
  logic [REGNO_W-1:0]   ex_rs2_regno;
  logic [REGNO_W-1:0]   ex_rd_regno;
  logic [XLEN-1:0]      ex_rs1_value;
  logic [XLEN-1:0]      ex_rs2_value;
  logic [XLEN-1:0]      ex_imm;
  logic [OPCLASS_W-1:0] ex_op_class;

  logic [XLEN-1:0] shadow_regs [NUM_REGS];   // Expected register file contents
  logic [6:0]      valid_opcodes [11] = '{OPC_OP, OPC_OP_32, OPC_OP_IMM, OPC_OP_IMM_32,
                                          OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_LUI,
                                          OPC_AUIPC, OPC_JAL, OPC_JALR};
  int              seed;
  string           test_name;

  decode_stage i_decode_stage (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s expected %h actual %h", test_name, what, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "Check failed");
    end
  endtask

  task automatic wait_valid(input int limit);
    int cycles;
    cycles = 0;
    while (ex_valid !== 1'b1 && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (ex_valid !== 1'b1) begin
      $display("Timeout in %s, ex_valid never went high", test_name);
      $display("TESTS FAILED");
      $fatal(1, "Timeout");
    end
  endtask

  // Expected fields straight from the RV64I encoding rules
  function automatic void model_decode(
    input  logic [ILEN-1:0]      ins,
    output logic [OPCLASS_W-1:0] cls,
    output logic [REGNO_W-1:0]   rs1,
    output logic [REGNO_W-1:0]   rs2,
    output logic [REGNO_W-1:0]   rd,
    output logic [XLEN-1:0]      imm
  );
    logic is_r;
    logic is_i;
    logic is_s;
    logic is_b;
    logic is_u;
    logic is_j;
    case (ins[6:0])
      OPC_OP, OPC_OP_32:         cls = CLS_ALU_REG;
      OPC_OP_IMM, OPC_OP_IMM_32: cls = CLS_ALU_IMM;
      OPC_LOAD:                  cls = CLS_LOAD;
      OPC_STORE:                 cls = CLS_STORE;
      OPC_BRANCH:                cls = CLS_BRANCH;
      OPC_LUI:                   cls = CLS_LUI;
      OPC_AUIPC:                 cls = CLS_AUIPC;
      OPC_JAL:                   cls = CLS_JAL;
      OPC_JALR:                  cls = CLS_JALR;
      default:                   cls = CLS_NONE;
    endcase
    is_r = (cls == CLS_ALU_REG);
    is_i = (cls == CLS_ALU_IMM) || (cls == CLS_LOAD) || (cls == CLS_JALR);
    is_s = (cls == CLS_STORE);
    is_b = (cls == CLS_BRANCH);
    is_u = (cls == CLS_LUI) || (cls == CLS_AUIPC);
    is_j = (cls == CLS_JAL);
    rs1 = (is_r || is_i || is_s || is_b) ? ins[19:15] : 5'd0;
    rs2 = (is_r || is_s || is_b) ? ins[24:20] : 5'd0;
    rd  = (is_r || is_i || is_u || is_j) ? ins[11:7] : 5'd0;
    if (is_i)
      imm = {{52{ins[31]}}, ins[31:20]};
    else if (is_s)
      imm = {{52{ins[31]}}, ins[31:25], ins[11:7]};
    else if (is_b)
      imm = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    else if (is_u)
      imm = {{32{ins[31]}}, ins[31:12], 12'b0};
    else if (is_j)
      imm = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    else
      imm = '0;                                // R format and illegal
  endfunction

  function automatic logic [ILEN-1:0] make_r(input logic [REGNO_W-1:0] rs1,
                                             input logic [REGNO_W-1:0] rs2,
                                             input logic [REGNO_W-1:0] rd);
    return {7'b0, rs2, rs1, 3'b000, rd, OPC_OP};
  endfunction

  task automatic check_outputs(input logic [ILEN-1:0] ins, input logic [XLEN-1:0] pc);
    logic [OPCLASS_W-1:0] cls;
    logic [REGNO_W-1:0]   rs1;
    logic [REGNO_W-1:0]   rs2;
    logic [REGNO_W-1:0]   rd;
    logic [XLEN-1:0]      imm;
    model_decode(ins, cls, rs1, rs2, rd, imm);
    check_value("ex_valid", 64'(1'b1), 64'(ex_valid));
    check_value("ex_pc_next", pc, ex_pc_next);
    check_value("ex_op_class", 64'(cls), 64'(ex_op_class));
    check_value("ex_rs1_regno", 64'(rs1), 64'(ex_rs1_regno));
    check_value("ex_rs2_regno", 64'(rs2), 64'(ex_rs2_regno));
    check_value("ex_rd_regno", 64'(rd), 64'(ex_rd_regno));
    check_value("ex_rs1_value", shadow_regs[rs1], ex_rs1_value);
    check_value("ex_rs2_value", shadow_regs[rs2], ex_rs2_value);
    check_value("ex_imm", imm, ex_imm);
  endtask

  task automatic check_bubble();
    check_value("ex_valid", 64'h0, 64'(ex_valid));
    check_value("ex_pc_next", 64'h0, ex_pc_next);
    check_value("ex_op_class", 64'h0, 64'(ex_op_class));
    check_value("ex_rs1_regno", 64'h0, 64'(ex_rs1_regno));
    check_value("ex_rs2_regno", 64'h0, 64'(ex_rs2_regno));
    check_value("ex_rd_regno", 64'h0, 64'(ex_rd_regno));
    check_value("ex_rs1_value", 64'h0, ex_rs1_value);
    check_value("ex_rs2_value", 64'h0, ex_rs2_value);
    check_value("ex_imm", 64'h0, ex_imm);
  endtask

  // Starts and ends on a falling edge
  task automatic decode_instr(input logic [ILEN-1:0] ins, input logic [XLEN-1:0] pc);
    instr         = ins;
    pc_next       = pc;
    flush         = 1'b0;
    decode_enable = 1'b1;
    @(negedge clk);
    decode_enable = 1'b0;
    wait_valid(8);
    check_outputs(ins, pc);
  endtask

  task automatic write_reg(input logic [REGNO_W-1:0] regno, input logic [XLEN-1:0] value);
    wb_enable = 1'b1;
    wb_regno  = regno;
    wb_value  = value;
    if (regno != 5'd0)
      shadow_regs[regno] = value;
    @(negedge clk);
    wb_enable = 1'b0;
  endtask

  task automatic test_register_file();
    logic [XLEN-1:0] value;
    test_name = "register_file";
    for (int r = 1; r < 8; r++) begin
      value = {$random(seed), $random(seed)};
      write_reg(5'(r), value);
    end
    decode_instr(make_r(5'd1, 5'd2, 5'd3), 64'h1000);
    decode_instr(make_r(5'd7, 5'd4, 5'd9), 64'h1004);
    decode_instr(make_r(5'd5, 5'd6, 5'd1), 64'h1008);
    write_reg(5'd0, 64'hdead_beef_cafe_f00d);
    decode_instr(make_r(5'd0, 5'd0, 5'd2), 64'h100c);
    value = 64'h0123_4567_89ab_cdef;          // Written in the decode cycle
    shadow_regs[3] = value;
    wb_enable = 1'b1;
    wb_regno  = 5'd3;
    wb_value  = value;
    decode_instr(make_r(5'd3, 5'd3, 5'd8), 64'h1010);
    wb_enable = 1'b0;
  endtask

  task automatic test_format_decode();
    logic [ILEN-1:0] ins;
    logic [XLEN-1:0] pc;
    int              idx;
    test_name = "format_decode";
    decode_instr(32'h002081b3, 64'h2000);     // add x3, x1, x2
    decode_instr(32'h402081bb, 64'h2004);
    decode_instr(32'hfff08293, 64'h2008);     // addi x5, x1, -1
    decode_instr(32'h8001031b, 64'h200c);
    decode_instr(32'hff813383, 64'h2010);     // ld x7, -8(x2)
    decode_instr(32'hfe313823, 64'h2014);     // sd x3, -16(x2)
    decode_instr(32'hfe208ee3, 64'h2018);
    decode_instr(32'h80000537, 64'h201c);     // lui x10, 0x80000
    decode_instr(32'h12345597, 64'h2020);
    decode_instr(32'hff9ff0ef, 64'h2024);     // jal x1, -8
    decode_instr(32'h00008067, 64'h2028);
    test_name = "random_decode";
    for (int n = 0; n < 200; n++) begin
      ins      = $random(seed);
      idx      = $unsigned($random(seed)) % 11;
      ins[6:0] = valid_opcodes[idx];
      pc       = {$random(seed), $random(seed)};
      decode_instr(ins, pc);
    end
  endtask

  task automatic test_flush();
    test_name     = "flush";
    instr         = 32'hfff08293;
    pc_next       = 64'h3000;
    decode_enable = 1'b1;
    flush         = 1'b1;
    @(negedge clk);
    decode_enable = 1'b0;
    flush         = 1'b0;
    check_bubble();
    decode_instr(32'hfff08293, 64'h3004);
  endtask

  task automatic test_hold();
    logic [ILEN-1:0] held;
    held      = 32'hfe313823;
    test_name = "hold";
    decode_instr(held, 64'h4000);
    for (int n = 0; n < 6; n++) begin
      instr   = $random(seed);
      pc_next = {$random(seed), $random(seed)};
      flush   = n[0];
      @(negedge clk);
      check_outputs(held, 64'h4000);
    end
    flush = 1'b0;
  endtask

  task automatic test_illegal_opcode();
    test_name = "illegal_opcode";
    write_reg(5'd31, 64'h5a5a_5a5a_a5a5_a5a5);
    decode_instr(32'hffff_ffff, 64'h5000);    // Fields would point at x31
    decode_instr(32'h1234_5677, 64'h5004);
    decode_instr(32'h0000_0000, 64'h5008);
  endtask

  initial begin
    seed          = 32'h7ba32966;
    rst_n         = 1'b0;
    decode_enable = 1'b0;
    flush         = 1'b0;
    pc_next       = '0;
    instr         = '0;
    wb_enable     = 1'b0;
    wb_regno      = '0;
    wb_value      = '0;
    for (int k = 0; k < NUM_REGS; k++) begin
      shadow_regs[k] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n     = 1'b1;
    test_name = "reset_state";
    check_bubble();
    test_register_file();
    test_format_decode();
    test_flush();
    test_hold();
    test_illegal_opcode();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== rv_decode.f ====
verilog/rv_decode_pkg.sv
verilog/instr_field_decoder.sv
verilog/register_file.sv
verilog/decode_stage.sv
test/decode_stage_sva.sv
test/tb_decode_stage.sv

// ==== Makefile ====
# Verilator flow for the RV64I decode stage

VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= rv_decode.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SEED      ?= 1
JOBS      ?= 0

LINT_FLAGS  ?= --lint-only --timing --assert
BUILD_FLAGS ?= --binary --timing --assert -j $(JOBS)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
